/* hw/csr_cfg_params.svh */
// ----------------------------------------------------------
// Width, window and FIFO sizing macros for the CSR index
// configuration loader
// ----------------------------------------------------------
`ifndef csr_cfg_params_svh
`define csr_cfg_params_svh

// Data path widths
`define csr_word_w      32
`define csr_addr_w      64
`define csr_shift_w     5

// Words per configuration window
`define csr_seq_len     16

// FIFO sizing, shared by both queues
`define csr_fifo_depth  16
`define csr_prog_thresh 8

// Encoded field widths
`define csr_cmd_w       3
`define csr_buf_w       4

`endif

/* hw/mem_resp_pkg.sv */
// ----------------------------------------------------------
// Memory response side types: buffer classes and the
// queued response word
// ----------------------------------------------------------
`include "csr_cfg_params.svh"

package mem_resp_pkg;

    // Buffer class carried with every read response
    typedef enum logic [`csr_buf_w-1:0] {
        buf_none         = `csr_buf_w'(0),
        buf_cu_setup     = `csr_buf_w'(1),
        buf_engine_setup = `csr_buf_w'(2),
        buf_index        = `csr_buf_w'(3),
        buf_edges        = `csr_buf_w'(4),
        buf_weights      = `csr_buf_w'(5),
        buf_aux          = `csr_buf_w'(6)
    } buffer_class_t;

    // ----------------------------------------------------------
    // Response FIFO entry
    // ----------------------------------------------------------
    // First marks the word whose sequence number equals the window base
    typedef struct packed {
        logic                   first;
        logic [`csr_word_w-1:0] data;
    } resp_word_t;

endpackage

/* hw/csr_cfg_pkg.sv */
// ----------------------------------------------------------
// Assembled index configuration: command codes, the packed
// configuration record and the word position names
// ----------------------------------------------------------
`include "csr_cfg_params.svh"

package csr_cfg_pkg;

    // Memory command carried in word 5
    typedef enum logic [`csr_cmd_w-1:0] {
        cmd_invalid      = `csr_cmd_w'(0),
        cmd_mem_read     = `csr_cmd_w'(1),
        cmd_mem_write    = `csr_cmd_w'(2),
        cmd_stream_read  = `csr_cmd_w'(3),
        cmd_stream_write = `csr_cmd_w'(4)
    } cmd_t;

    // ----------------------------------------------------------
    // Configuration record
    // ----------------------------------------------------------
    typedef struct packed {
        logic                          increment;
        logic                          decrement;
        logic                          mode_sequence;
        logic                          mode_buffer;
        logic                          mode_break;
        logic [`csr_word_w-1:0]        index_start;
        logic [`csr_word_w-1:0]        index_end;
        logic [`csr_word_w-1:0]        stride;
        logic [`csr_shift_w-1:0]       granularity;
        logic                          direction;
        cmd_t                          cmd;
        mem_resp_pkg::buffer_class_t   buffer;
        logic [`csr_addr_w-1:0]        array_pointer;
        logic [`csr_word_w-1:0]        array_size;
    } csr_cfg_t;

    // Word positions inside one window, 10 and up fill nothing
    typedef enum logic [$clog2(`csr_seq_len)-1:0] {
        fld_mode        = 0,
        fld_index_start = 1,
        fld_index_end   = 2,
        fld_stride      = 3,
        fld_granularity = 4,
        fld_cmd_buffer  = 5,
        fld_reserved    = 6,
        fld_pointer_lo  = 7,
        fld_pointer_hi  = 8,
        fld_array_size  = 9
    } cfg_field_t;

endpackage

/* hw/fifo_if.sv */
// ----------------------------------------------------------
// FIFO write and read bundle, typed by its payload
// ----------------------------------------------------------
`timescale 1ns/1ps

interface fifo_if #(
    parameter type data_t = logic
) ();

    // Write side
    logic  wr_en;
    data_t din;
    logic  full;
    logic  almost_full;

    // Read side, valid follows an honored rd_en by one cycle
    logic  rd_en;
    data_t dout;
    logic  valid;

    modport writer (
        output wr_en, din,
        input  full, almost_full
    );

    modport reader (
        output rd_en,
        input  dout, valid
    );

    modport fifo (
        input  wr_en, din, rd_en,
        output full, almost_full, dout, valid
    );

endinterface

/* hw/sync_fifo.sv */
// ----------------------------------------------------------
// Synchronous FIFO with registered dout, one-cycle valid
// and registered full / almost-full flags
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "csr_cfg_params.svh"

module sync_fifo #(
    parameter type data_t = logic,
    parameter int  depth  = `csr_fifo_depth
) (
    input logic ap_clk,
    input logic areset_csr_index_generator,
    fifo_if.fifo bus
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = $clog2(depth + 1);

    data_t            mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_nxt;
    logic             wr_ok;
    logic             rd_ok;

    // Writes while full are dropped, reads while empty ignored
    assign wr_ok     = bus.wr_en & ~bus.full;
    assign rd_ok     = bus.rd_en & (count != '0);
    assign count_nxt = count + cnt_w'(wr_ok) - cnt_w'(rd_ok);

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            bus.full        <= 1'b0;
            bus.almost_full <= 1'b0;
            bus.valid       <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count           <= count_nxt;
            bus.full        <= (count_nxt == cnt_w'(depth));
            bus.almost_full <= (count_nxt >= cnt_w'(`csr_prog_thresh));
            bus.valid       <= rd_ok;
        end
    end

    // Storage and read data
    always_ff @(posedge ap_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= bus.din;
        end
        if (rd_ok) begin
            bus.dout <= mem[rd_ptr];
        end
    end

endmodule

/* hw/resp_filter.sv */
// ----------------------------------------------------------
// Response filter: registers each memory response and pushes
// setup-class words whose sequence number is in the window
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "csr_cfg_params.svh"

module resp_filter #(
    parameter int seq_base = 0
) (
    input logic                         ap_clk,
    input logic                         areset_csr_index_generator,
    input logic                         resp_valid,
    input mem_resp_pkg::buffer_class_t  resp_class,
    input logic [`csr_addr_w-1:0]       resp_offset,
    input logic [`csr_shift_w-1:0]      resp_shift,
    input logic [`csr_word_w-1:0]       resp_data,
    fifo_if.writer                      resp_fifo
);

    localparam logic [`csr_addr_w-1:0] seq_lo = `csr_addr_w'(seq_base);
    localparam logic [`csr_addr_w-1:0] seq_hi = `csr_addr_w'(seq_base + `csr_seq_len);

    logic                        valid_q;
    mem_resp_pkg::buffer_class_t class_q;
    logic [`csr_addr_w-1:0]      offset_q;
    logic [`csr_shift_w-1:0]     shift_q;
    logic [`csr_word_w-1:0]      data_q;
    logic [`csr_addr_w-1:0]      seq_num;
    logic                        is_setup;
    logic                        in_window;
    logic                        push_q;
    mem_resp_pkg::resp_word_t    word_q;

    // ----------------------------------------------------------
    // Stage 1: capture the response
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        class_q  <= resp_class;
        offset_q <= resp_offset;
        shift_q  <= resp_shift;
        data_q   <= resp_data;
    end

    // Word sequence number and acceptance tests
    assign seq_num   = offset_q >> shift_q;
    assign is_setup  = (class_q == mem_resp_pkg::buf_cu_setup) ||
                       (class_q == mem_resp_pkg::buf_engine_setup);
    assign in_window = (seq_num >= seq_lo) && (seq_num < seq_hi);

    // ----------------------------------------------------------
    // Stage 2: push accepted words
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            push_q <= 1'b0;
        end else begin
            push_q <= valid_q & is_setup & in_window;
        end
    end

    always_ff @(posedge ap_clk) begin
        word_q.first <= (seq_num == seq_lo);
        word_q.data  <= data_q;
    end

    assign resp_fifo.wr_en = push_q;
    assign resp_fifo.din   = word_q;

endmodule

/* hw/cfg_assembler.sv */
// ----------------------------------------------------------
// Configuration assembler: one-hot word sequencer, field
// decoder and the push of each completed configuration
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "csr_cfg_params.svh"

module cfg_assembler (
    input logic    ap_clk,
    input logic    areset_csr_index_generator,
    fifo_if.reader resp_fifo,
    fifo_if.writer cfg_fifo
);

    localparam int seq_idx_w = $clog2(`csr_seq_len);

    logic [`csr_seq_len-1:0]  seq_q;
    logic                     emit_q;
    logic                     push_q;
    logic                     emit_pending;
    logic                     word_valid_q;
    mem_resp_pkg::resp_word_t word_q;
    logic [`csr_word_w-1:0]   d;
    csr_cfg_pkg::cfg_field_t  fld;
    csr_cfg_pkg::csr_cfg_t    cfg_q;

    // Position of the single set bit
    function automatic logic [seq_idx_w-1:0] onehot_index(
        input logic [`csr_seq_len-1:0] oh
    );
        logic [seq_idx_w-1:0] idx;
        idx = '0;
        for (int i = 0; i < `csr_seq_len; i++) begin
            if (oh[i]) begin
                idx = seq_idx_w'(i);
            end
        end
        return idx;
    endfunction

    // ----------------------------------------------------------
    // Pop control
    // ----------------------------------------------------------
    // Hold off from the moment the last word is in flight until emit ends,
    // so no word of the next window lands on a full sequencer
    assign emit_pending = (resp_fifo.valid & seq_q[`csr_seq_len-2]) |
                          seq_q[`csr_seq_len-1] | emit_q;

    // FIFO itself ignores rd_en while empty
    assign resp_fifo.rd_en = ~cfg_fifo.almost_full & ~emit_pending;

    // ----------------------------------------------------------
    // Sequencer and emit
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            seq_q        <= '0;
            emit_q       <= 1'b0;
            push_q       <= 1'b0;
            word_valid_q <= 1'b0;
        end else begin
            emit_q       <= seq_q[`csr_seq_len-1] & ~emit_q;
            push_q       <= emit_q;
            word_valid_q <= resp_fifo.valid;
            if (emit_q) begin
                seq_q <= '0;
            end else if (resp_fifo.valid) begin
                // Only a first-flag word opens a window
                if (resp_fifo.dout.first && (seq_q == '0)) begin
                    seq_q <= `csr_seq_len'(1);
                end else begin
                    seq_q <= seq_q << 1;
                end
            end
        end
    end

    // Delayed word, decoded against the updated sequencer
    always_ff @(posedge ap_clk) begin
        word_q <= resp_fifo.dout;
    end

    assign d   = word_q.data;
    assign fld = csr_cfg_pkg::cfg_field_t'(onehot_index(seq_q));

    // ----------------------------------------------------------
    // Field decoder
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            cfg_q <= '0;
        end else if (word_valid_q && (seq_q != '0)) begin
            case (fld)
                csr_cfg_pkg::fld_mode: begin
                    cfg_q.increment     <= d[0];
                    cfg_q.decrement     <= d[1];
                    cfg_q.mode_sequence <= d[2];
                    cfg_q.mode_buffer   <= d[3];
                    cfg_q.mode_break    <= d[4];
                end
                csr_cfg_pkg::fld_index_start: cfg_q.index_start <= d;
                csr_cfg_pkg::fld_index_end:   cfg_q.index_end   <= d;
                csr_cfg_pkg::fld_stride:      cfg_q.stride      <= d;
                csr_cfg_pkg::fld_granularity: begin
                    cfg_q.granularity <= d[`csr_shift_w-1:0];
                    cfg_q.direction   <= d[`csr_word_w-1];
                end
                csr_cfg_pkg::fld_cmd_buffer: begin
                    cfg_q.cmd    <= csr_cfg_pkg::cmd_t'(d[`csr_cmd_w-1:0]);
                    cfg_q.buffer <= mem_resp_pkg::buffer_class_t'(d[`csr_cmd_w +: `csr_buf_w]);
                end
                csr_cfg_pkg::fld_pointer_lo: cfg_q.array_pointer[`csr_word_w-1:0] <= d;
                csr_cfg_pkg::fld_pointer_hi: begin
                    cfg_q.array_pointer[`csr_addr_w-1:`csr_word_w] <= d;
                end
                csr_cfg_pkg::fld_array_size: cfg_q.array_size <= d;
                // Word 6 and words 10 to 15 are consumed only
                default: begin
                end
            endcase
        end
    end

    assign cfg_fifo.wr_en = push_q;
    assign cfg_fifo.din   = cfg_q;

endmodule

/* hw/csr_index_config_memory.sv */
// ----------------------------------------------------------
// CSR index configuration loader top: response filter,
// response and configuration FIFOs, assembler, output stage
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "csr_cfg_params.svh"

module csr_index_config_memory #(
    parameter int seq_base = 0
) (
    input  logic                         ap_clk,
    input  logic                         areset_csr_index_generator,
    input  logic                         resp_valid,
    input  mem_resp_pkg::buffer_class_t  resp_class,
    input  logic [`csr_addr_w-1:0]       resp_offset,
    input  logic [`csr_shift_w-1:0]      resp_shift,
    input  logic [`csr_word_w-1:0]       resp_data,
    input  logic                         cfg_rd_en,
    output logic                         cfg_valid,
    output csr_cfg_pkg::csr_cfg_t        cfg_out
);

    logic cfg_rd_en_q;

    fifo_if #(.data_t(mem_resp_pkg::resp_word_t)) resp_fifo_bus ();
    fifo_if #(.data_t(csr_cfg_pkg::csr_cfg_t))    cfg_fifo_bus  ();

    // ----------------------------------------------------------
    // Response path
    // ----------------------------------------------------------
    resp_filter #(
        .seq_base(seq_base)
    ) i_resp_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_class                (resp_class),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_data                 (resp_data),
        .resp_fifo                 (resp_fifo_bus.writer)
    );

    sync_fifo #(
        .data_t(mem_resp_pkg::resp_word_t),
        .depth (`csr_fifo_depth)
    ) i_resp_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .bus                       (resp_fifo_bus.fifo)
    );

    cfg_assembler i_cfg_assembler (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_fifo                 (resp_fifo_bus.reader),
        .cfg_fifo                  (cfg_fifo_bus.writer)
    );

    sync_fifo #(
        .data_t(csr_cfg_pkg::csr_cfg_t),
        .depth (`csr_fifo_depth)
    ) i_cfg_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .bus                       (cfg_fifo_bus.fifo)
    );

    // ----------------------------------------------------------
    // Consumer side
    // ----------------------------------------------------------
    // Level read enable, registered before it reaches the FIFO
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            cfg_rd_en_q <= 1'b0;
            cfg_valid   <= 1'b0;
        end else begin
            cfg_rd_en_q <= cfg_rd_en;
            cfg_valid   <= cfg_fifo_bus.valid;
        end
    end

    // Empty FIFO drops the pop internally
    assign cfg_fifo_bus.rd_en = cfg_rd_en_q;

    always_ff @(posedge ap_clk) begin
        cfg_out <= cfg_fifo_bus.dout;
    end

endmodule

/* test/tb_csr_index_config_memory.sv */
// ----------------------------------------------------------
// Testbench for the CSR index configuration loader: clock,
// reset, stimulus file reader, output checker and timeouts
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "csr_cfg_params.svh"

module tb_csr_index_config_memory;

    localparam int timeout_cycles = 200;
    localparam int quiet_cycles   = 20;

    logic                         ap_clk;
    logic                         areset_csr_index_generator;
    logic                         resp_valid;
    mem_resp_pkg::buffer_class_t  resp_class;
    logic [`csr_addr_w-1:0]       resp_offset;
    logic [`csr_shift_w-1:0]      resp_shift;
    logic [`csr_word_w-1:0]       resp_data;
    logic                         cfg_rd_en;
    logic                         cfg_valid;
    csr_cfg_pkg::csr_cfg_t        cfg_out;

    csr_cfg_pkg::csr_cfg_t        exp_q[$];
    string                        name_q[$];
    logic                         paused;
    logic                         done;
    logic [31:0]                  lcg_state;
    integer                       fd;
    integer                       code;
    logic [8*8-1:0]               tag;
    logic [8*32-1:0]              name_r;
    logic [8*256-1:0]             line;
    logic [63:0]                  fv [16];

    csr_index_config_memory #(
        .seq_base(0)
    ) i_csr_index_config_memory (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .resp_valid                (resp_valid),
        .resp_class                (resp_class),
        .resp_offset               (resp_offset),
        .resp_shift                (resp_shift),
        .resp_data                 (resp_data),
        .cfg_rd_en                 (cfg_rd_en),
        .cfg_valid                 (cfg_valid),
        .cfg_out                   (cfg_out)
    );

    always #4 ap_clk = ~ap_clk;

    task automatic stop_with_error(input string msg);
        $display("Error: %0s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %0s, field %0s: expected %0h, actual %0h",
                     test, field, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Output check failed");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------
    // Word k of a window, unused bits carry random filler
    function automatic logic [31:0] encode_word(input int k, input csr_cfg_pkg::csr_cfg_t c);
        logic [31:0] w;
        w = lcg_next();
        case (k)
            0: w[4:0] = {c.mode_break, c.mode_buffer, c.mode_sequence, c.decrement, c.increment};
            1: w = c.index_start;
            2: w = c.index_end;
            3: w = c.stride;
            4: begin
                w[4:0] = c.granularity;
                w[31]  = c.direction;
            end
            5: begin
                w[2:0] = c.cmd;
                w[6:3] = c.buffer;
            end
            7: w = c.array_pointer[31:0];
            8: w = c.array_pointer[63:32];
            9: w = c.array_size;
            default: begin
            end
        endcase
        return w;
    endfunction

    task automatic send_word(input logic [3:0] cls, input logic [63:0] off,
                             input logic [4:0] sh, input logic [31:0] data);
        @(negedge ap_clk);
        resp_valid  = 1'b1;
        resp_class  = mem_resp_pkg::buffer_class_t'(cls);
        resp_offset = off;
        resp_shift  = sh;
        resp_data   = data;
    endtask

    task automatic end_burst();
        @(negedge ap_clk);
        resp_valid = 1'b0;
    endtask

    task automatic send_sequence(input logic [3:0] cls, input logic [1:0] noise,
                                 input csr_cfg_pkg::csr_cfg_t c);
        for (int k = 0; k < `csr_seq_len; k++) begin
            send_word(cls, 64'(k * 4), 5'd2, encode_word(k, c));
            if (noise == 2'd1) begin
                // In-window offset, data buffer class
                send_word(4'd3, 64'(k * 4), 5'd2, lcg_next());
            end else if (noise == 2'd2) begin
                // Beyond the window through the offset or through the shift
                if (k >= 4) begin
                    send_word(cls, 64'(k * 4), 5'd0, lcg_next());
                end else begin
                    send_word(cls, 64'((k + 16) * 4), 5'd2, lcg_next());
                end
            end
        end
        end_burst();
    endtask

    // One loop per outstanding configuration, each with its own timeout
    task automatic wait_for_drain();
        int waited;
        int pending;
        while (exp_q.size() > 0) begin
            pending = exp_q.size();
            waited  = 0;
            while (exp_q.size() == pending) begin
                @(negedge ap_clk);
                waited++;
                if (waited > timeout_cycles) begin
                    stop_with_error("a configuration did not arrive within 200 cycles");
                end
            end
        end
    endtask

    // ----------------------------------------------------------
    // Output checker
    // ----------------------------------------------------------
    task automatic compare_output();
        csr_cfg_pkg::csr_cfg_t e;
        string                 n;
        if (paused) begin
            stop_with_error("a configuration left while cfg_rd_en was held low");
        end else if (exp_q.size() == 0) begin
            stop_with_error("a configuration arrived when none was expected");
        end else begin
            e = exp_q.pop_front();
            n = name_q.pop_front();
            check_value(n, "increment", 64'(e.increment), 64'(cfg_out.increment));
            check_value(n, "decrement", 64'(e.decrement), 64'(cfg_out.decrement));
            check_value(n, "mode_sequence", 64'(e.mode_sequence), 64'(cfg_out.mode_sequence));
            check_value(n, "mode_buffer", 64'(e.mode_buffer), 64'(cfg_out.mode_buffer));
            check_value(n, "mode_break", 64'(e.mode_break), 64'(cfg_out.mode_break));
            check_value(n, "index_start", 64'(e.index_start), 64'(cfg_out.index_start));
            check_value(n, "index_end", 64'(e.index_end), 64'(cfg_out.index_end));
            check_value(n, "stride", 64'(e.stride), 64'(cfg_out.stride));
            check_value(n, "granularity", 64'(e.granularity), 64'(cfg_out.granularity));
            check_value(n, "direction", 64'(e.direction), 64'(cfg_out.direction));
            check_value(n, "cmd", 64'(e.cmd), 64'(cfg_out.cmd));
            check_value(n, "buffer", 64'(e.buffer), 64'(cfg_out.buffer));
            check_value(n, "array_pointer", e.array_pointer, cfg_out.array_pointer);
            check_value(n, "array_size", 64'(e.array_size), 64'(cfg_out.array_size));
        end
    endtask

    always @(negedge ap_clk) begin
        if (!areset_csr_index_generator && cfg_valid === 1'b1) begin
            compare_output();
        end
    end

    // ----------------------------------------------------------
    // Stimulus file records
    // ----------------------------------------------------------
    task automatic run_record(input logic [8*8-1:0] rec);
        csr_cfg_pkg::csr_cfg_t c;
        if (rec == "#") begin
            code = $fgets(line, fd);
        end else if (rec == "W") begin
            code = $fscanf(fd, "%h %h %h %h", fv[0], fv[1], fv[2], fv[3]);
            if (code != 4) begin
                stop_with_error("malformed word record in the stimulus file");
            end
            send_word(fv[0][3:0], fv[1], fv[2][4:0], fv[3][31:0]);
            end_burst();
        end else if (rec == "R") begin
            code = $fscanf(fd, "%h", fv[0]);
            if (code != 1) begin
                stop_with_error("malformed read-enable record in the stimulus file");
            end
            // Pause flag moves after the checker has sampled this edge
            if (fv[0][0] == 1'b0) begin
                wait_for_drain();
                @(negedge ap_clk);
                paused    <= 1'b1;
                cfg_rd_en = 1'b0;
            end else begin
                @(negedge ap_clk);
                paused    <= 1'b0;
                cfg_rd_en = 1'b1;
            end
        end else if (rec == "E") begin
            code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           name_r, fv[0], fv[1], fv[2], fv[3], fv[4], fv[5], fv[6],
                           fv[7], fv[8], fv[9], fv[10], fv[11], fv[12], fv[13],
                           fv[14], fv[15]);
            if (code != 17) begin
                stop_with_error("malformed expected-configuration record");
            end
            c               = '0;
            c.increment     = fv[2][0];
            c.decrement     = fv[3][0];
            c.mode_sequence = fv[4][0];
            c.mode_buffer   = fv[5][0];
            c.mode_break    = fv[6][0];
            c.index_start   = fv[7][31:0];
            c.index_end     = fv[8][31:0];
            c.stride        = fv[9][31:0];
            c.granularity   = fv[10][4:0];
            c.direction     = fv[11][0];
            c.cmd           = csr_cfg_pkg::cmd_t'(fv[12][2:0]);
            c.buffer        = mem_resp_pkg::buffer_class_t'(fv[13][3:0]);
            c.array_pointer = fv[14];
            c.array_size    = fv[15][31:0];
            exp_q.push_back(c);
            name_q.push_back($sformatf("%0s", name_r));
            send_sequence(fv[0][3:0], fv[1][1:0], c);
        end else begin
            stop_with_error("unknown record type in the stimulus file");
        end
    endtask

    initial begin
        ap_clk                     = 1'b0;
        areset_csr_index_generator = 1'b1;
        resp_valid                 = 1'b0;
        resp_class                 = mem_resp_pkg::buf_none;
        resp_offset                = '0;
        resp_shift                 = '0;
        resp_data                  = '0;
        cfg_rd_en                  = 1'b1;
        paused                     <= 1'b0;
        done                       = 1'b0;
        lcg_state                  = 32'd62;
        fd = $fopen("test/csr_cfg_stim.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open test/csr_cfg_stim.txt");
        end
        repeat (2) @(posedge ap_clk);
        @(negedge ap_clk);
        areset_csr_index_generator = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                done = 1'b1;
            end else begin
                run_record(tag);
            end
        end
        $fclose(fd);
        wait_for_drain();
        // Quiet period, a repeated configuration would still show up here
        repeat (quiet_cycles) @(negedge ap_clk);
        if (exp_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "Expected configurations left over");
        end
    end

endmodule

/* test/csr_cfg_stim.txt */
# W class offset shift data | R rd_en | E name class noise inc dec seq buf brk
# istart iend stride gran dir cmd buffer pointer size (hex; noise 1 class, 2 window)
R 1
E field_assembly 1 0 1 0 1 0 1 00000010 000000ff 00000004 03 0 1 1 0000000180000000 00000100
E class_filter 1 1 0 1 0 1 0 00001000 00000000 fffffffc 1f 1 2 2 00000000deadbee0 00000040
E window_filter 1 2 1 1 0 0 1 00000005 00000105 00000008 05 0 3 4 123456789abcdef0 00000200
W 1 40 2 44444444
W 1 48 0 55555555
W 1 c 2 11111111
W 1 14 2 22222222
W 2 3c 2 33333333
E start_rule 2 0 0 0 1 1 0 00000020 00000040 00000001 0a 1 4 5 0000000400001000 00000080
R 0
E backpressure_a 1 0 1 0 0 0 0 00000000 00000010 00000001 02 0 1 3 0000000010000000 00000010
E backpressure_b 2 0 0 1 0 0 0 00000010 00000020 00000002 03 1 2 4 0000000020000000 00000020
E backpressure_c 2 0 0 0 1 1 1 00000020 00000030 00000003 04 0 4 6 0000000030000000 00000030
R 1

/* filelist.f */
+incdir+hw
hw/mem_resp_pkg.sv
hw/csr_cfg_pkg.sv
hw/fifo_if.sv
hw/sync_fifo.sv
hw/resp_filter.sv
hw/cfg_assembler.sv
hw/csr_index_config_memory.sv
test/tb_csr_index_config_memory.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CSR index configuration loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_csr_index_config_memory
log=sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module "$top" -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/V"$top" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "ERRORS FOUND" "$log"; then
    echo "Simulation failed"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation passed"
exit 0
